// File: hdl/cache_pkg.sv
package cache_pkg;

	localparam int LINE_BITS = 256;
	localparam int LINE_BYTES = 32;
	localparam int NUM_SETS = 8;
	localparam int INDEX_BITS = 3;
	localparam int OFFSET_BITS = 5;
	localparam int TAG_BITS = 24;
	localparam int NUM_WAYS = 2;

	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [LINE_BYTES-1:0] line_mask_t;

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [INDEX_BITS-1:0] index;
		logic [OFFSET_BITS-1:0] offset;	// byte within the line
	} cache_addr_t;

	typedef struct packed {
		cache_addr_t addr;
		logic [31:0] wdata;
		logic [3:0] mask;	// byte mask of the word
		logic write;
	} cpu_req_t;

	typedef struct packed {
		cpu_req_t req;
		logic [NUM_WAYS-1:0] hit;
		logic victim_way;
		logic victim_dirty;
		logic [TAG_BITS-1:0] victim_tag;
		logic lru;	// set lru bit at lookup
	} stage_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITEBACK,
		ST_FILL,
		ST_UPDATE
	} miss_state_e;

endpackage : cache_pkg

// File: hdl/cache_tag_array.sv
`timescale 1ns/1ns

module cache_tag_array
(
	input logic clk,
	input logic rst,
	input logic [cache_pkg::INDEX_BITS-1:0] index_i,
	input logic [cache_pkg::TAG_BITS-1:0] tag_i,
	input logic wr_way_i,
	input logic fill_we_i,
	input logic dirty_we_i,
	input logic dirty_val_i,
	input logic lru_we_i,
	input logic lru_val_i,
	output logic [cache_pkg::NUM_WAYS-1:0] hit_o,
	output logic victim_dirty_o,
	output logic [cache_pkg::TAG_BITS-1:0] victim_tag_o,
	output logic lru_o
);

logic [cache_pkg::TAG_BITS-1:0] tags [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] valid_q;
logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] dirty_q;
logic [cache_pkg::NUM_SETS-1:0] lru_q;
logic [cache_pkg::INDEX_BITS-1:0] wr_index_q;	// set looked up last cycle
logic [cache_pkg::TAG_BITS-1:0] wr_tag_q;

always_comb
begin
	for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
	begin
		hit_o[w] = valid_q[w][index_i] && (tags[w][index_i] == tag_i);
	end
	lru_o = lru_q[index_i];
	victim_dirty_o = dirty_q[lru_q[index_i]][index_i];	// lru names the victim
	victim_tag_o = tags[lru_q[index_i]][index_i];
end

// writes land in the set of the staged request, which is the previous lookup
always_ff @(posedge clk)
begin
	wr_index_q <= index_i;
	wr_tag_q <= tag_i;
	if (fill_we_i)
		tags[wr_way_i][wr_index_q] <= wr_tag_q;
end

always_ff @(posedge clk)
begin
	if (rst)
	begin
		valid_q <= '0;
		dirty_q <= '0;
		lru_q <= '0;
	end
	else
	begin
		if (fill_we_i)
		begin
			valid_q[wr_way_i][wr_index_q] <= 1'b1;
			dirty_q[wr_way_i][wr_index_q] <= 1'b0;	// fresh line is clean
		end
		else if (dirty_we_i)
			dirty_q[wr_way_i][wr_index_q] <= dirty_val_i;
		if (lru_we_i)
			lru_q[wr_index_q] <= lru_val_i;
	end
end

endmodule : cache_tag_array

// File: hdl/cache_data_array.sv
`timescale 1ns/1ns

module cache_data_array
(
	input logic clk,
	input logic [cache_pkg::INDEX_BITS-1:0] index_i,
	input logic way_i,
	input logic we_i,
	input cache_pkg::line_mask_t mask_i,
	input cache_pkg::line_t wdata_i,
	output cache_pkg::line_t rdata0_o,
	output cache_pkg::line_t rdata1_o
);

cache_pkg::line_t lines [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

always_ff @(posedge clk)
begin
	if (we_i)
	begin
		for (int b = 0; b < cache_pkg::LINE_BYTES; b++)
		begin
			if (mask_i[b])
				lines[way_i][index_i][8*b +: 8] <= wdata_i[8*b +: 8];
		end
	end
end

assign rdata0_o = lines[0][index_i];
assign rdata1_o = lines[1][index_i];

endmodule : cache_data_array

// File: hdl/cache_stage_regs.sv
`timescale 1ns/1ns

module cache_stage_regs
(
	input logic clk,
	input logic rst,
	input logic load_i,
	input logic stall_i,
	input cache_pkg::stage_t stage_i,

	output cache_pkg::stage_t stage_o,
	output logic stall_o,
	output logic stall2_o
);

cache_pkg::stage_t stage_q;
logic stall_q;
logic stall2_q;

always_ff @(posedge clk)
begin
	if (rst)
	begin
		stage_q <= '0;
		stall_q <= 1'b0;
		stall2_q <= 1'b0;
	end
	else
	begin
		if (load_i)
			stage_q <= stage_i;	// holds while a miss is served
		stall_q <= stall_i;
		stall2_q <= stall_q;
	end
end

always_comb
begin
	stage_o = stage_q;
	stall_o = stall_q;
	stall2_o = stall2_q;
end

endmodule : cache_stage_regs

// File: hdl/cache_miss_ctrl.sv
`timescale 1ns/1ns

module cache_miss_ctrl
(
	input logic clk,
	input logic rst,
	input cache_pkg::stage_t stage_i,
	input logic valid_req_i,
	input logic mem_resp_i,

	output logic stall_o,
	output logic mem_read_o,
	output logic mem_write_o,
	output logic [31:0] mem_addr_o,
	output logic fill_we_o
);

cache_pkg::miss_state_e state_q;
cache_pkg::miss_state_e state_d;
logic miss;

assign miss = valid_req_i && (stage_i.hit == '0);

always_ff @(posedge clk)
begin
	if (rst)
		state_q <= cache_pkg::ST_IDLE;
	else
		state_q <= state_d;
end

// the stage register reloads once as the FSM leaves idle, so the
// victim fields seen in writeback already include the last hit's update
always_comb
begin
	state_d = state_q;
	case (state_q)
		cache_pkg::ST_IDLE:
		begin
			if (miss)
				state_d = cache_pkg::ST_WRITEBACK;
		end
		cache_pkg::ST_WRITEBACK:
		begin
			if (!stage_i.victim_dirty || mem_resp_i)
				state_d = cache_pkg::ST_FILL;	// clean victim skips memory
		end
		cache_pkg::ST_FILL:
		begin
			if (mem_resp_i)
				state_d = cache_pkg::ST_UPDATE;
		end
		cache_pkg::ST_UPDATE:
			state_d = cache_pkg::ST_IDLE;
		default:
			state_d = cache_pkg::ST_IDLE;
	endcase
end

always_comb
begin
	stall_o = (state_q != cache_pkg::ST_IDLE);
	mem_write_o = (state_q == cache_pkg::ST_WRITEBACK) && stage_i.victim_dirty;
	mem_read_o = (state_q == cache_pkg::ST_FILL);
	fill_we_o = (state_q == cache_pkg::ST_UPDATE);
end

always_comb
begin
	if (state_q == cache_pkg::ST_WRITEBACK)
	begin
		mem_addr_o = {stage_i.victim_tag, stage_i.req.addr.index,
			{cache_pkg::OFFSET_BITS{1'b0}}};	// victim line
	end
	else
	begin
		mem_addr_o = {stage_i.req.addr.tag, stage_i.req.addr.index,
			{cache_pkg::OFFSET_BITS{1'b0}}};
	end
end

endmodule : cache_miss_ctrl

// File: hdl/pipelined_cache.sv
`timescale 1ns/1ns

module pipelined_cache
(
	input logic clk,
	input logic rst,

	input cache_pkg::cpu_req_t cpu_req_i,
	input logic cpu_read_i,
	input logic cpu_write_i,
	output logic [31:0] cpu_rdata_o,
	output logic cpu_resp_o,

	output logic [31:0] mem_addr_o,
	output cache_pkg::line_t mem_wdata_o,
	output logic mem_read_o,
	output logic mem_write_o,
	input cache_pkg::line_t mem_rdata_i,
	input logic mem_resp_i
);

cache_pkg::stage_t stage_d;
cache_pkg::stage_t stage_q;
logic [cache_pkg::NUM_WAYS-1:0] hit;
logic victim_dirty;
logic [cache_pkg::TAG_BITS-1:0] victim_tag;
logic lru;
logic stall;
logic stall_q;
logic stall2_q;
logic valid_q;
logic valid_req;
logic fill_we;
logic hit_way;
logic access_hit;
logic write_hit;
logic data_way;
logic [2:0] word_sel;
cache_pkg::line_t rdata0;
cache_pkg::line_t rdata1;
cache_pkg::line_t hit_line;
cache_pkg::line_t fill_line_q;
cache_pkg::line_t wdata_line;
cache_pkg::line_mask_t wmask;

always_comb
begin
	stage_d.req = cpu_req_i;
	stage_d.req.write = cpu_write_i;	// level decides, not the struct bit
	stage_d.hit = hit;
	stage_d.victim_way = lru;
	stage_d.victim_dirty = victim_dirty;
	stage_d.victim_tag = victim_tag;
	stage_d.lru = lru;
end

always_ff @(posedge clk)
begin
	if (rst)
		valid_q <= 1'b0;
	else if (!stall)
		valid_q <= cpu_read_i | cpu_write_i;
end

always_ff @(posedge clk)
begin
	if (mem_resp_i)
		fill_line_q <= mem_rdata_i;	// written back in ST_UPDATE
end

// stale entry through release and re-lookup
assign valid_req = valid_q && !stall_q && !stall2_q;

always_comb
begin
	hit_way = stage_q.hit[1];
	access_hit = valid_q && (stage_q.hit != '0);
	write_hit = access_hit && stage_q.req.write;
	word_sel = stage_q.req.addr.offset[cache_pkg::OFFSET_BITS-1:2];
	hit_line = hit_way ? rdata1 : rdata0;
	cpu_rdata_o = hit_line[32*word_sel +: 32];
	cpu_resp_o = access_hit;
	wmask = cache_pkg::line_mask_t'(stage_q.req.mask) << (4*word_sel);
	data_way = fill_we ? stage_q.victim_way : hit_way;
	wdata_line = fill_we ? fill_line_q : {8{stage_q.req.wdata}};
	mem_wdata_o = stage_q.lru ? rdata1 : rdata0;	// victim line
end

cache_tag_array tag_array_i
(
	.clk(clk),
	.rst(rst),
	.index_i(cpu_req_i.addr.index),
	.tag_i(cpu_req_i.addr.tag),
	.wr_way_i(data_way),
	.fill_we_i(fill_we),
	.dirty_we_i(write_hit),
	.dirty_val_i(1'b1),
	.lru_we_i(access_hit),
	.lru_val_i(~hit_way),	// point at the way not used
	.hit_o(hit),
	.victim_dirty_o(victim_dirty),
	.victim_tag_o(victim_tag),
	.lru_o(lru)
);

cache_data_array data_array_i
(
	.clk(clk),
	.index_i(stage_q.req.addr.index),
	.way_i(data_way),
	.we_i(fill_we | write_hit),
	.mask_i(fill_we ? {cache_pkg::LINE_BYTES{1'b1}} : wmask),
	.wdata_i(wdata_line),
	.rdata0_o(rdata0),
	.rdata1_o(rdata1)
);

cache_stage_regs stage_regs_i
(
	.clk(clk),
	.rst(rst),
	.load_i(!stall),
	.stall_i(stall),
	.stage_i(stage_d),
	.stage_o(stage_q),
	.stall_o(stall_q),
	.stall2_o(stall2_q)
);

cache_miss_ctrl miss_ctrl_i
(
	.clk(clk),
	.rst(rst),
	.stage_i(stage_q),
	.valid_req_i(valid_req),
	.mem_resp_i(mem_resp_i),
	.stall_o(stall),
	.mem_read_o(mem_read_o),
	.mem_write_o(mem_write_o),
	.mem_addr_o(mem_addr_o),
	.fill_we_o(fill_we)
);

endmodule : pipelined_cache

// File: tb/line_memory_model.sv
`timescale 1ns/1ns

module line_memory_model
(
	input logic clk,
	input logic [31:0] mem_addr_i,
	input cache_pkg::line_t mem_wdata_i,
	input logic mem_read_i,
	input logic mem_write_i,
	output cache_pkg::line_t mem_rdata_o,
	output logic mem_resp_o
);

cache_pkg::line_t lines [256];	// addr[12:5] picks the line
int read_count;
int write_count;
int op_count;
int last_read_op;
int last_write_op;
int busy_cycles;
logic [31:0] last_read_addr;
logic [31:0] last_write_addr;
cache_pkg::line_t last_write_line;

initial
begin
	mem_rdata_o = '0;
	mem_resp_o = 1'b0;
	read_count = 0;
	write_count = 0;
	op_count = 0;
	last_read_op = 0;
	last_write_op = 0;
	busy_cycles = 0;
	last_read_addr = '0;
	last_write_addr = '0;
	last_write_line = '0;
	void'($urandom(32'h9d76_2e50));
	for (int i = 0; i < 256; i++)
		for (int w = 0; w < 8; w++)
			lines[i][32*w +: 32] = $urandom;
	forever
	begin
		@(posedge clk);
		#2;
		if (mem_resp_o)
		begin
			mem_resp_o = 1'b0;	// one-cycle pulse
			busy_cycles = 0;
		end
		if (mem_read_i || mem_write_i)	// a new level may follow the pulse at once
		begin
			busy_cycles++;
			if (busy_cycles == 3)
			begin
				op_count++;
				if (mem_write_i)
				begin
					lines[mem_addr_i[12:5]] = mem_wdata_i;
					write_count++;
					last_write_op = op_count;
					last_write_addr = mem_addr_i;
					last_write_line = mem_wdata_i;
				end
				else
				begin
					mem_rdata_o = lines[mem_addr_i[12:5]];
					read_count++;
					last_read_op = op_count;
					last_read_addr = mem_addr_i;
				end
				mem_resp_o = 1'b1;
			end
		end
	end
end

endmodule : line_memory_model

// File: tb/tb_pipelined_cache.sv
`timescale 1ns/1ns

module tb_pipelined_cache;

logic clk;
logic rst;
cache_pkg::cpu_req_t cpu_req;
logic cpu_read;
logic cpu_write;
logic [31:0] cpu_rdata;
logic cpu_resp;
logic [31:0] mem_addr;
cache_pkg::line_t mem_wdata;
logic mem_read;
logic mem_write;
cache_pkg::line_t mem_rdata;
logic mem_resp;

logic [31:0] ref_mem [2048];	// memory image plus cpu writes
int errors;
int checks;
int resp_wait;	// cycles from drive to response
bit hung;

pipelined_cache dut_i
(
	.clk(clk),
	.rst(rst),
	.cpu_req_i(cpu_req),
	.cpu_read_i(cpu_read),
	.cpu_write_i(cpu_write),
	.cpu_rdata_o(cpu_rdata),
	.cpu_resp_o(cpu_resp),
	.mem_addr_o(mem_addr),
	.mem_wdata_o(mem_wdata),
	.mem_read_o(mem_read),
	.mem_write_o(mem_write),
	.mem_rdata_i(mem_rdata),
	.mem_resp_i(mem_resp)
);

line_memory_model mem_i
(
	.clk(clk),
	.mem_addr_i(mem_addr),
	.mem_wdata_i(mem_wdata),
	.mem_read_i(mem_read),
	.mem_write_i(mem_write),
	.mem_rdata_o(mem_rdata),
	.mem_resp_o(mem_resp)
);

initial
begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	if (got !== exp)
	begin
		$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		errors++;
	end
endtask

task automatic compare_line(input string name, input cache_pkg::line_t got,
	input cache_pkg::line_t exp);
	checks++;
	if (got !== exp)
	begin
		$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		errors++;
	end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp)
	begin
		$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		errors++;
	end
endtask

task automatic compare_count(input string name, input int got, input int exp);
	checks++;
	if (got != exp)
	begin
		$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
		errors++;
	end
endtask

function automatic logic [31:0] make_addr(input logic [23:0] tag, input logic [2:0] index,
	input logic [2:0] word);
	return {tag, index, word, 2'b00};
endfunction

function automatic cache_pkg::line_t ref_line(input logic [31:0] addr);
	cache_pkg::line_t line;
	for (int w = 0; w < 8; w++)
		line[32*w +: 32] = ref_mem[{addr[12:5], 3'(w)}];
	return line;
endfunction

function automatic void ref_store(input logic [31:0] addr, input logic [31:0] wdata,
	input logic [3:0] mask);
	for (int b = 0; b < 4; b++)
		if (mask[b])
			ref_mem[addr[12:2]][8*b +: 8] = wdata[8*b +: 8];
endfunction

task automatic drive_request(input logic [31:0] addr, input logic write,
	input logic [31:0] wdata, input logic [3:0] mask);
	cpu_req.addr = addr;
	cpu_req.wdata = wdata;
	cpu_req.mask = mask;
	cpu_req.write = write;
	cpu_read = !write;
	cpu_write = write;
endtask

// holds the request level until the response pulse
task automatic cpu_access(input logic [31:0] addr, input logic write, input logic [31:0] wdata,
	input logic [3:0] mask, output logic [31:0] rdata);
	bit done;
	done = 1'b0;
	resp_wait = 0;
	drive_request(addr, write, wdata, mask);
	while (!done && !hung)
	begin
		@(posedge clk);
		#2;
		resp_wait++;
		if (cpu_resp)
			done = 1'b1;
		else if (resp_wait >= 200)
		begin
			$display("timeout: no CPU response for address 0x%h after %0d cycles",
				addr, resp_wait);
			errors++;
			hung = 1'b1;
		end
	end
	rdata = cpu_rdata;
	cpu_read = 1'b0;
	cpu_write = 1'b0;
endtask

task automatic report_test(input string name, input int start);
	$display("test %s: %s", name, (errors == start) ? "ok" : "FAILED");
endtask

task automatic test_first_miss();
	int start;
	int reads;
	int writes;
	logic [31:0] addr;
	logic [31:0] rdata;
	start = errors;
	reads = mem_i.read_count;
	writes = mem_i.write_count;
	compare_bit("cpu_resp_o", cpu_resp, 1'b0);
	compare_bit("mem_read_o", mem_read, 1'b0);
	compare_bit("mem_write_o", mem_write, 1'b0);
	addr = make_addr(24'h11, 3'd2, 3'd5);
	cpu_access(addr, 1'b0, '0, '0, rdata);
	compare_word("cpu_rdata_o", rdata, ref_mem[addr[12:2]]);
	compare_count("mem_read_o count", mem_i.read_count - reads, 1);
	compare_count("mem_write_o count", mem_i.write_count - writes, 0);
	compare_word("mem_addr_o", mem_i.last_read_addr, {addr[31:5], 5'b0});
	report_test("first read miss", start);
endtask

task automatic test_repeat_hit();
	int start;
	int reads;
	logic [31:0] addr;
	logic [31:0] rdata;
	start = errors;
	reads = mem_i.read_count + mem_i.write_count;
	addr = make_addr(24'h11, 3'd2, 3'd1);
	cpu_access(addr, 1'b0, '0, '0, rdata);
	compare_word("cpu_rdata_o", rdata, ref_mem[addr[12:2]]);
	compare_count("cpu_resp_o latency", resp_wait, 1);
	compare_count("memory accesses", mem_i.read_count + mem_i.write_count - reads, 0);
	report_test("repeated read hit", start);
endtask

task automatic test_write_merge();
	int start;
	int reads;
	logic [31:0] addr;
	logic [31:0] rdata;
	start = errors;
	reads = mem_i.read_count + mem_i.write_count;
	addr = make_addr(24'h11, 3'd2, 3'd5);
	cpu_access(addr, 1'b1, 32'ha5c3_96e1, 4'b0110, rdata);
	ref_store(addr, 32'ha5c3_96e1, 4'b0110);
	compare_count("cpu_resp_o latency", resp_wait, 1);
	cpu_access(addr, 1'b0, '0, '0, rdata);
	compare_word("cpu_rdata_o", rdata, ref_mem[addr[12:2]]);
	compare_count("memory accesses", mem_i.read_count + mem_i.write_count - reads, 0);
	report_test("partial write hit", start);
endtask

task automatic test_dirty_evict();
	int start;
	int reads;
	int writes;
	logic [31:0] addr;
	logic [31:0] rdata;
	start = errors;
	reads = mem_i.read_count;
	writes = mem_i.write_count;
	addr = make_addr(24'h05, 3'd2, 3'd0);	// fills the empty way
	cpu_access(addr, 1'b0, '0, '0, rdata);
	compare_word("cpu_rdata_o", rdata, ref_mem[addr[12:2]]);
	compare_count("mem_write_o count", mem_i.write_count - writes, 0);
	addr = make_addr(24'h1a, 3'd2, 3'd7);	// evicts the dirty line
	cpu_access(addr, 1'b0, '0, '0, rdata);
	compare_word("cpu_rdata_o", rdata, ref_mem[addr[12:2]]);
	compare_count("mem_read_o count", mem_i.read_count - reads, 2);
	compare_count("mem_write_o count", mem_i.write_count - writes, 1);
	compare_word("mem_addr_o", mem_i.last_write_addr, make_addr(24'h11, 3'd2, 3'd0));
	compare_line("mem_wdata_o", mem_i.last_write_line, ref_line(make_addr(24'h11, 3'd2, 3'd0)));
	if (mem_i.last_write_op > mem_i.last_read_op)
	begin
		$display("writeback of the dirty line came after the fill");
		errors++;
	end
	report_test("dirty victim eviction", start);
endtask

task automatic test_back_to_back();
	int start;
	int accesses;
	logic [31:0] addr;
	start = errors;
	accesses = mem_i.read_count + mem_i.write_count;
	addr = make_addr(24'h05, 3'd2, 3'd0);
	drive_request(addr, 1'b0, '0, '0);
	for (int k = 0; k < 5; k++)
	begin
		@(posedge clk);
		#2;
		compare_bit("cpu_resp_o", cpu_resp, 1'b1);
		compare_word("cpu_rdata_o", cpu_rdata, ref_mem[addr[12:2]]);
		if (k < 4)
		begin
			addr = make_addr((k % 2 == 0) ? 24'h1a : 24'h05, 3'd2, 3'((k + 1) * 3));
			drive_request(addr, 1'b0, '0, '0);
		end
		else
			cpu_read = 1'b0;
	end
	compare_count("memory accesses", mem_i.read_count + mem_i.write_count - accesses, 0);
	report_test("back-to-back hits", start);
endtask

task automatic test_clean_evict();
	int start;
	int reads;
	int writes;
	logic [31:0] addr;
	logic [31:0] rdata;
	start = errors;
	reads = mem_i.read_count;
	writes = mem_i.write_count;
	addr = make_addr(24'h0c, 3'd2, 3'd4);
	cpu_access(addr, 1'b0, '0, '0, rdata);
	compare_word("cpu_rdata_o", rdata, ref_mem[addr[12:2]]);
	compare_count("mem_read_o count", mem_i.read_count - reads, 1);
	compare_count("mem_write_o count", mem_i.write_count - writes, 0);
	compare_word("mem_addr_o", mem_i.last_read_addr, {addr[31:5], 5'b0});
	report_test("clean victim eviction", start);
endtask

initial
begin
	errors = 0;
	checks = 0;
	resp_wait = 0;
	hung = 1'b0;
	rst = 1'b1;
	cpu_req = '0;
	cpu_read = 1'b0;
	cpu_write = 1'b0;
	repeat (4) @(posedge clk);
	#2;
	rst = 1'b0;
	for (int i = 0; i < 2048; i++)
		ref_mem[i] = mem_i.lines[i / 8][32*(i % 8) +: 32];
	if (!hung)
		test_first_miss();
	if (!hung)
		test_repeat_hit();
	if (!hung)
		test_write_merge();
	if (!hung)
		test_dirty_evict();
	if (!hung)
		test_back_to_back();
	if (!hung)
		test_clean_evict();
	$display("checks: %0d, errors: %0d", checks, errors);
	if (errors == 0 && !hung)
		$display("*** TEST PASSED ***");
	else
		$display("*** TEST FAILED ***");
	$finish;
end

endmodule : tb_pipelined_cache

// File: files.f
hdl/cache_pkg.sv
hdl/cache_tag_array.sv
hdl/cache_data_array.sv
hdl/cache_stage_regs.sv
hdl/cache_miss_ctrl.sv
hdl/pipelined_cache.sv
tb/line_memory_model.sv
tb/tb_pipelined_cache.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_pipelined_cache \
	-Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/Vtb_pipelined_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
fi
exit 1
